//--- Makefile
TOP = tb_bgsub

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
verilog/bgsub_pkg.sv
verilog/rgb_to_gray.sv
verilog/pixel_fifo.sv
verilog/model_memory.sv
verilog/sigma_delta_update.sv
verilog/frame_control.sv
verilog/bgsub_top.sv
tests/tb_bgsub.sv

//--- tests/tb_bgsub.sv
// Testbench for the sigma-delta background subtractor
// Scene stimulus from a Galois LFSR, reference model of the mean and
// variance update, output order and sop/eop framing checks, timeout
`default_nettype none

module tb_bgsub;

    localparam int IMAGE_WIDTH  = 8;
    localparam int IMAGE_HEIGHT = 4;
    localparam int N_FACTOR     = 4;
    localparam int FIFO_DEPTH   = 8;
    localparam int PIXELS       = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int FRAMES       = 6;
    localparam int TOTAL        = FRAMES * PIXELS;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = FRAMES * PIXELS * 8;
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    logic              clk;
    logic              rst_n;
    bgsub_pkg::rgb_t   data_in;
    logic              valid_in;
    logic              ready_out;
    bgsub_pkg::pixel_t data_out;
    logic              valid_out;
    logic              ready_in;
    logic              sop_out;
    logic              eop_out;

    logic [31:0]       lfsr;
    bgsub_pkg::rgb_t   scene [PIXELS];
    int                ref_mean [PIXELS];
    int                ref_var [PIXELS];
    logic [7:0]        exp_q [$];
    int                accepted  = 0;
    int                out_words = 0;
    int                errors    = 0;
    int                checks    = 0;
    int                cycles    = 0;

    bgsub_top #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT),
        .N_FACTOR     (N_FACTOR),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .valid_in  (valid_in),
        .ready_out (ready_out),
        .data_out  (data_out),
        .valid_out (valid_out),
        .ready_in  (ready_in),
        .sop_out   (sop_out),
        .eop_out   (eop_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------
    // One LFSR step per bit, shifted-out bit collected MSB first
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] result;
        logic        b;
        result = '0;
        for (int i = 0; i < n; i++) begin
            b      = lfsr[0];
            lfsr   = (lfsr >> 1) ^ (b ? LFSR_POLY : 32'h0);
            result = {result[30:0], b};
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] time %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // Reference model, one call per accepted pixel in input order
    function automatic logic [7:0] expected_mask(input bgsub_pkg::rgb_t pix, input int index);
        int addr;
        int gray;
        int ot;
        int target;
        addr = index % PIXELS;
        gray = (int'(pix.r) + 2 * int'(pix.g) + int'(pix.b)) / 4;
        // First frame only seeds the model
        if (index < PIXELS) begin
            ref_mean[addr] = gray;
            ref_var[addr]  = int'(bgsub_pkg::VAR_MIN);
            return bgsub_pkg::MASK_BG;
        end
        if (gray > ref_mean[addr]) begin
            ref_mean[addr] = ref_mean[addr] + 1;
        end else if (gray < ref_mean[addr]) begin
            ref_mean[addr] = ref_mean[addr] - 1;
        end
        ot     = (ref_mean[addr] > gray) ? ref_mean[addr] - gray : gray - ref_mean[addr];
        target = ot * N_FACTOR;
        if (target > 255) begin
            target = 255;
        end
        // Variance one level toward the target, then the clamp
        if (target > ref_var[addr]) begin
            ref_var[addr] = ref_var[addr] + 1;
        end else if (target < ref_var[addr]) begin
            ref_var[addr] = ref_var[addr] - 1;
        end
        if (ref_var[addr] < int'(bgsub_pkg::VAR_MIN)) begin
            ref_var[addr] = int'(bgsub_pkg::VAR_MIN);
        end else if (ref_var[addr] > int'(bgsub_pkg::VAR_MAX)) begin
            ref_var[addr] = int'(bgsub_pkg::VAR_MAX);
        end
        return (ot >= ref_var[addr]) ? bgsub_pkg::MASK_FG : bgsub_pkg::MASK_BG;
    endfunction

    // --------------------
    // Monitor
    // --------------------
    // Values seen here are the ones held through the cycle just ended
    always @(posedge clk) begin
        if (rst_n) begin
            if (valid_in) begin
                if (!ready_out) begin
                    errors++;
                    $display("valid_in was high while ready_out was low at time %0t", $time);
                end
                exp_q.push_back(expected_mask(data_in, accepted));
                accepted++;
            end
            if (valid_out) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Output word at time %0t has no accepted pixel to match it",
                             $time);
                end else begin
                    check_value("data_out", data_out, exp_q.pop_front());
                end
                check_value("sop_out", sop_out, (out_words % PIXELS) == 0);
                check_value("eop_out", eop_out, (out_words % PIXELS) == PIXELS - 1);
                out_words++;
            end else begin
                // Framing marks only with a transfer
                check_value("sop_out", sop_out, 0);
                check_value("eop_out", eop_out, 0);
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES + RESET_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        int              sent;
        int              frame;
        int              addr;
        int              blk_start;
        int              blk_len;
        logic            go;
        logic            valid_d2;
        bgsub_pkg::rgb_t pix;

        rst_n     = 1'b0;
        data_in   = '0;
        valid_in  = 1'b0;
        ready_in  = 1'b0;
        lfsr      = 32'hee6d;
        sent      = 0;
        blk_start = 0;
        blk_len   = 0;
        valid_d2  = 1'b0;

        // Fixed background scene
        for (int i = 0; i < PIXELS; i++) begin
            scene[i] = 24'(take_bits(24));
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n    <= 1'b1;
        ready_in <= 1'b1;
        @(posedge clk);
        check_value("ready_out", ready_out, 1);
        check_value("valid_out", valid_out, 0);
        check_value("sop_out", sop_out, 0);
        check_value("eop_out", eop_out, 0);

        while (sent < TOTAL) begin
            if ((sent / PIXELS) % 2 == 1) begin
                // Odd frames starve the output so both FIFOs fill up
                ready_in <= (take_bits(2) == 0);
            end else begin
                ready_in <= (take_bits(2) != 0);
            end
            go = (take_bits(2) != 0);
            // ready_out stays high next cycle if no gray word lands at this edge
            if (go && ready_out && !valid_d2) begin
                frame = sent / PIXELS;
                addr  = sent % PIXELS;
                // New moving block at the start of each later frame
                if (addr == 0 && frame > 0) begin
                    blk_start = int'(take_bits(5));
                    blk_len   = int'(take_bits(3)) + 1;
                end
                pix = scene[addr];
                if (frame > 0 && addr >= blk_start && addr < blk_start + blk_len) begin
                    pix.r = pix.r + 8'h80;
                    pix.g = pix.g + 8'h80;
                    pix.b = pix.b + 8'h80;
                end else if (pix.g < 8'd252) begin
                    // Small sensor noise
                    pix.g = pix.g + 8'(take_bits(2));
                end
                data_in  <= pix;
                valid_in <= 1'b1;
                sent++;
            end else begin
                valid_in <= 1'b0;
            end
            valid_d2 = valid_in;
            @(posedge clk);
        end
        valid_in <= 1'b0;

        // Drain under random back-pressure
        while (out_words < TOTAL) begin
            @(posedge clk);
            ready_in <= (take_bits(2) != 0);
            @(negedge clk);
        end
        @(posedge clk);
        ready_in <= 1'b1;
        repeat (20) @(posedge clk);

        check_value("expected queue size", exp_q.size(), 0);
        check_value("output word count", out_words, accepted);
        $display("Checks: %0d, errors: %0d, words out: %0d, pixels accepted: %0d",
                 checks, errors, out_words, accepted);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bgsub_pkg.sv
// Shared definitions for the sigma-delta background subtractor
// Pixel width, variance limits and mask codes
// Pixel, RGB and model word types
`default_nettype none

package bgsub_pkg;

    // --------------------
    // Widths and limits
    // --------------------
    localparam int PIXEL_W = 8;

    // Variance clamp range
    localparam logic [PIXEL_W-1:0] VAR_MIN = 8'd2;
    localparam logic [PIXEL_W-1:0] VAR_MAX = 8'd250;

    // Mask codes
    localparam logic [PIXEL_W-1:0] MASK_FG = 8'hFF;
    localparam logic [PIXEL_W-1:0] MASK_BG = 8'h00;

    // --------------------
    // Types
    // --------------------
    typedef logic [PIXEL_W-1:0] pixel_t;

    // Blue in the high byte, red in the low byte
    typedef struct packed {
        pixel_t b;
        pixel_t g;
        pixel_t r;
    } rgb_t;

    // One model word per pixel location
    typedef struct packed {
        pixel_t mean;
        pixel_t variance;
    } model_t;

endpackage

`default_nettype wire

//--- verilog/bgsub_top.sv
// Sigma-delta background subtractor top level
// Gray stage, input FIFO, model memory, update stage, output FIFO
// Control block paces pops and frames the output stream
`default_nettype none

module bgsub_top #(
    parameter int IMAGE_WIDTH  = 320,
    parameter int IMAGE_HEIGHT = 240,
    parameter int N_FACTOR     = 4,
    parameter int FIFO_DEPTH   = 8
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire bgsub_pkg::rgb_t    data_in,
    input  wire logic               valid_in,
    output logic                    ready_out,
    output bgsub_pkg::pixel_t       data_out,
    output logic                    valid_out,
    input  wire logic               ready_in,
    output logic                    sop_out,
    output logic                    eop_out
);

    localparam int PIXELS = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int ADDR_W = (PIXELS > 1) ? $clog2(PIXELS) : 1;

    bgsub_pkg::pixel_t gray;
    logic              gray_valid;
    bgsub_pkg::pixel_t in_dout;
    logic              in_empty;
    logic              in_afull;
    logic              out_empty;
    logic              out_afull;
    logic              pop;
    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] wr_addr;
    logic              first_frame;
    bgsub_pkg::model_t rd_model;
    bgsub_pkg::model_t wr_model;
    logic              model_we;
    bgsub_pkg::pixel_t mask;
    logic              mask_valid;

    // --------------------
    // Input side
    // --------------------
    rgb_to_gray u_gray (
        .clk        (clk),
        .rst_n      (rst_n),
        .rgb        (data_in),
        .valid      (valid_in),
        .gray       (gray),
        .gray_valid (gray_valid)
    );

    // One slot kept for the pixel in the gray stage
    pixel_fifo #(.DEPTH(FIFO_DEPTH), .SLACK(1)) u_in_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (gray_valid),
        .din         (gray),
        .pop         (pop),
        .dout        (in_dout),
        .empty       (in_empty),
        .almost_full (in_afull)
    );

    assign ready_out = !in_afull;

    // --------------------
    // Model pipeline
    // --------------------
    model_memory #(.DEPTH(PIXELS)) u_model (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_model),
        .wr_en   (model_we),
        .wr_addr (wr_addr),
        .wr_data (wr_model)
    );

    sigma_delta_update #(.N_FACTOR(N_FACTOR)) u_update (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel       (in_dout),
        .pixel_valid (pop),
        .first_frame (first_frame),
        .model_in    (rd_model),
        .model_out   (wr_model),
        .model_we    (model_we),
        .mask        (mask),
        .mask_valid  (mask_valid)
    );

    // --------------------
    // Output side
    // --------------------
    // Two slots kept for the pixel and mask stages
    pixel_fifo #(.DEPTH(FIFO_DEPTH), .SLACK(2)) u_out_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (mask_valid),
        .din         (mask),
        .pop         (valid_out),
        .dout        (data_out),
        .empty       (out_empty),
        .almost_full (out_afull)
    );

    assign valid_out = ready_in && !out_empty;

    frame_control #(
        .IMAGE_WIDTH  (IMAGE_WIDTH),
        .IMAGE_HEIGHT (IMAGE_HEIGHT)
    ) u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_empty        (in_empty),
        .out_almost_full (out_afull),
        .pop             (pop),
        .rd_addr         (rd_addr),
        .wr_addr         (wr_addr),
        .first_frame     (first_frame),
        .out_valid       (valid_out),
        .sop             (sop_out),
        .eop             (eop_out)
    );

endmodule

`default_nettype wire

//--- verilog/frame_control.sv
// Pipeline control
// Pop decision, model read and write addresses, first-frame flag
// Output pixel counter for start and end of frame marks
`default_nettype none

module frame_control #(
    parameter int IMAGE_WIDTH  = 8,
    parameter int IMAGE_HEIGHT = 4
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    in_empty,
    input  wire logic                    out_almost_full,
    output logic                         pop,
    output logic [((IMAGE_WIDTH * IMAGE_HEIGHT > 1) ?
                   $clog2(IMAGE_WIDTH * IMAGE_HEIGHT) : 1)-1:0] rd_addr,
    output logic [((IMAGE_WIDTH * IMAGE_HEIGHT > 1) ?
                   $clog2(IMAGE_WIDTH * IMAGE_HEIGHT) : 1)-1:0] wr_addr,
    output logic                         first_frame,
    input  wire logic                    out_valid,
    output logic                         sop,
    output logic                         eop
);

    localparam int PIXELS = IMAGE_WIDTH * IMAGE_HEIGHT;
    localparam int ADDR_W = (PIXELS > 1) ? $clog2(PIXELS) : 1;
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(PIXELS - 1);

    logic              pop_q;
    logic [ADDR_W-1:0] out_cnt;

    // Output FIFO slack covers both pipeline stages
    assign pop = !in_empty && !out_almost_full;

    // --------------------
    // Model addressing
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr     <= '0;
            wr_addr     <= '0;
            pop_q       <= 1'b0;
            first_frame <= 1'b1;
        end else begin
            if (pop) begin
                rd_addr <= (rd_addr == LAST_ADDR) ? '0 : rd_addr + 1'b1;
            end
            // Write address trails the read by the memory latency
            wr_addr <= rd_addr;
            pop_q   <= pop;
            // Drops once the last location has been seeded
            if (pop_q && wr_addr == LAST_ADDR) begin
                first_frame <= 1'b0;
            end
        end
    end

    // --------------------
    // Output framing
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cnt <= '0;
        end else if (out_valid) begin
            out_cnt <= (out_cnt == LAST_ADDR) ? '0 : out_cnt + 1'b1;
        end
    end

    assign sop = out_valid && (out_cnt == '0);
    assign eop = out_valid && (out_cnt == LAST_ADDR);

    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        (32'(rd_addr) < PIXELS) && (32'(out_cnt) < PIXELS));

endmodule

`default_nettype wire

//--- verilog/model_memory.sv
// Per-pixel model store, one mean and variance word per location
// Single write port, synchronous read with one cycle of latency
`default_nettype none

module model_memory #(
    parameter int DEPTH = 32
) (
    input  wire logic                                       clk,
    input  wire logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] rd_addr,
    output bgsub_pkg::model_t                               rd_data,
    input  wire logic                                       wr_en,
    input  wire logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] wr_addr,
    input  wire bgsub_pkg::model_t                          wr_data
);

    // Contents are undefined until the first frame has passed
    bgsub_pkg::model_t mem [DEPTH];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // --------------------
    // Read port
    // --------------------
    // Address sampled every cycle, data valid next cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- verilog/pixel_fifo.sv
// Synchronous pixel FIFO
// Circular buffer with occupancy count, head shown on dout
// almost_full leaves SLACK slots for words already in flight
`default_nettype none

module pixel_fifo #(
    parameter int DEPTH = 8,
    parameter int SLACK = 1
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               push,
    input  wire bgsub_pkg::pixel_t  din,
    input  wire logic               pop,
    output bgsub_pkg::pixel_t       dout,
    output logic                    empty,
    output logic                    almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bgsub_pkg::pixel_t  mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // --------------------
    // Status
    // --------------------
    assign dout        = mem[rd_ptr];
    assign empty       = (count == '0);
    assign full        = (count == CNT_W'(DEPTH));
    // Free slots at most SLACK
    assign almost_full = (count >= CNT_W'(DEPTH - SLACK));

    // Upstream must respect almost_full, downstream must respect empty
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

//--- verilog/rgb_to_gray.sv
// RGB to gray conversion stage
// Gray level is (r + 2g + b) / 4, registered with its valid bit
`default_nettype none

module rgb_to_gray (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire bgsub_pkg::rgb_t   rgb,
    input  wire logic              valid,
    output bgsub_pkg::pixel_t      gray,
    output logic                   gray_valid
);

    // Two guard bits hold the weighted sum
    logic [bgsub_pkg::PIXEL_W+1:0] sum;

    // Green counts twice
    assign sum = {2'b00, rgb.r} + {1'b0, rgb.g, 1'b0} + {2'b00, rgb.b};

    // Valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gray_valid <= 1'b0;
        end else begin
            gray_valid <= valid;
        end
    end

    // Divide by four, truncated
    always_ff @(posedge clk) begin
        gray <= sum[bgsub_pkg::PIXEL_W+1:2];
    end

endmodule

`default_nettype wire

//--- verilog/sigma_delta_update.sv
// Sigma-delta model update and mask decision
// Pixel stage register, model arithmetic, mask and valid register
// First frame seeds the model and always reports background
`default_nettype none

module sigma_delta_update #(
    parameter int N_FACTOR = 4
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire bgsub_pkg::pixel_t  pixel,
    input  wire logic               pixel_valid,
    input  wire logic               first_frame,
    input  wire bgsub_pkg::model_t  model_in,
    output bgsub_pkg::model_t       model_out,
    output logic                    model_we,
    output bgsub_pkg::pixel_t       mask,
    output logic                    mask_valid
);

    localparam int W = bgsub_pkg::PIXEL_W;
    localparam logic [W-1:0] N_F = W'(N_FACTOR);

    bgsub_pkg::pixel_t pixel_q;
    logic              pixel_valid_q;
    logic [W-1:0]      mean_new;
    logic [W-1:0]      ot;
    logic [2*W-1:0]    scaled;
    logic [W-1:0]      target;
    logic [W-1:0]      var_step;
    logic [W-1:0]      var_new;
    logic [W-1:0]      mask_d;

    // --------------------
    // Pixel stage
    // --------------------
    // Lines up with the model word from the memory read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid_q <= 1'b0;
        end else begin
            pixel_valid_q <= pixel_valid;
        end
    end

    always_ff @(posedge clk) begin
        pixel_q <= pixel;
    end

    // --------------------
    // Model arithmetic
    // --------------------
    always_comb begin
        // Mean moves one level toward the pixel
        if (pixel_q > model_in.mean) begin
            mean_new = model_in.mean + 1'b1;
        end else if (pixel_q < model_in.mean) begin
            mean_new = model_in.mean - 1'b1;
        end else begin
            mean_new = model_in.mean;
        end

        // Absolute difference against the updated mean
        ot = (mean_new >= pixel_q) ? mean_new - pixel_q : pixel_q - mean_new;

        // Variance target, saturated to one byte
        scaled = {{W{1'b0}}, ot} * {{W{1'b0}}, N_F};
        target = (scaled > {{W{1'b0}}, {W{1'b1}}}) ? {W{1'b1}} : scaled[W-1:0];

        // Variance steps one level toward the target
        if (target > model_in.variance) begin
            var_step = model_in.variance + 1'b1;
        end else if (target < model_in.variance) begin
            var_step = model_in.variance - 1'b1;
        end else begin
            var_step = model_in.variance;
        end

        // Clamp into the allowed band
        if (var_step < bgsub_pkg::VAR_MIN) begin
            var_new = bgsub_pkg::VAR_MIN;
        end else if (var_step > bgsub_pkg::VAR_MAX) begin
            var_new = bgsub_pkg::VAR_MAX;
        end else begin
            var_new = var_step;
        end

        // First frame seeds mean from the pixel
        if (first_frame) begin
            model_out.mean     = pixel_q;
            model_out.variance = bgsub_pkg::VAR_MIN;
            mask_d             = bgsub_pkg::MASK_BG;
        end else begin
            model_out.mean     = mean_new;
            model_out.variance = var_new;
            mask_d = (ot >= var_new) ? bgsub_pkg::MASK_FG : bgsub_pkg::MASK_BG;
        end
    end

    // Write back in the same cycle the old word arrives
    assign model_we = pixel_valid_q;

    // --------------------
    // Mask stage
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_valid <= 1'b0;
        end else begin
            mask_valid <= pixel_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        mask <= mask_d;
    end

endmodule

`default_nettype wire
